// ==== Makefile ====
# Verilator flow for the core testbench
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "sim: pass message not found"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== core_ctrl.sv ====
/* Core control */
module core_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  stage_if.dst                         wb,
  output logic                         o_fetch_start,
  output logic [core_pkg::XLEN-1:0]    o_fetch_pc,
  output logic                         o_rf_wen,
  output logic [core_pkg::RIDX_W-1:0]  o_rf_waddr,
  output logic [core_pkg::XLEN-1:0]    o_rf_wdata,
  output logic                         o_commit_valid,
  output logic [core_pkg::XLEN-1:0]    o_commit_pc,
  output logic [core_pkg::ILEN-1:0]    o_commit_inst,
  output logic [core_pkg::RIDX_W-1:0]  o_commit_rd,
  output logic [core_pkg::XLEN-1:0]    o_commit_wdata,
  output logic                         o_halt
);

  core_pkg::ctrl_state_e        state;
  logic [core_pkg::XLEN-1:0]    pc;
  logic                         commit;
  logic                         is_ebreak;

  assign wb.ack = (state == core_pkg::ST_WAIT);
  assign commit = wb.req & wb.ack;

  // EBREAK is 0x00100073.
  assign is_ebreak = (wb.inst[6:0] == core_pkg::OPC_SYSTEM) && (wb.inst[31:7] == 25'h0002000);

  assign o_fetch_start = (state == core_pkg::ST_FETCH);
  assign o_fetch_pc    = pc;
  assign o_halt        = (state == core_pkg::ST_HALT);

  // Register file write lands on the commit edge.
  assign o_rf_wen   = commit & wb.rd_wen;
  assign o_rf_waddr = wb.rd;
  assign o_rf_wdata = wb.rd_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= core_pkg::ST_IDLE;
      pc             <= core_pkg::RESET_PC;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= commit;
      case (state)
        core_pkg::ST_IDLE:  state <= core_pkg::ST_FETCH;
        core_pkg::ST_FETCH: state <= core_pkg::ST_WAIT;  // One-cycle start pulse.
        core_pkg::ST_WAIT: begin
          if (commit) begin
            pc    <= wb.next_pc;
            state <= is_ebreak ? core_pkg::ST_HALT : core_pkg::ST_FETCH;
          end
        end
        default: state <= core_pkg::ST_HALT;  // Stays halted.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      o_commit_pc    <= wb.pc;
      o_commit_inst  <= wb.inst;
      o_commit_rd    <= wb.rd;
      o_commit_wdata <= wb.rd_wen ? wb.rd_wdata : '0;
    end
  end

endmodule

// ==== core_exec.sv ====
/* Execute stage */
module core_exec (
  input  logic  clk,
  input  logic  rst,
  stage_if.dst  i,
  stage_if.src  o,
  rf_if.user    rf
);

  localparam int XL = core_pkg::XLEN;

  core_pkg::opcode_e          opcode;
  core_pkg::alu_op_e          alu_op;
  core_pkg::alu_op_e          f3_alu;
  core_pkg::mem_op_e          mem_op;
  core_pkg::mem_op_e          mem_op_q;
  logic [XL-1:0]              imm_i;
  logic [XL-1:0]              imm_s;
  logic [XL-1:0]              imm_b;
  logic [XL-1:0]              imm_u;
  logic [XL-1:0]              imm_j;
  logic [XL-1:0]              op_a;
  logic [XL-1:0]              op_b;
  logic [XL-1:0]              alu_res;
  logic [XL-1:0]              next_pc;
  logic                       writes;
  logic                       rd_wen;
  logic                       hs;
  logic [XL-1:0]              pc_q;
  logic [core_pkg::ILEN-1:0]  inst_q;
  logic [core_pkg::RIDX_W-1:0] rd_q;
  logic                       rd_wen_q;
  logic [XL-1:0]              wdata_q;
  logic [XL-1:0]              store_q;
  logic [XL-1:0]              next_pc_q;

  assign opcode = core_pkg::opcode_e'(i.inst[6:0]);
  assign rf.rs1 = i.inst[19:15];
  assign rf.rs2 = i.inst[24:20];

  assign imm_i = {{(XL-12){i.inst[31]}}, i.inst[31:20]};
  assign imm_s = {{(XL-12){i.inst[31]}}, i.inst[31:25], i.inst[11:7]};
  assign imm_b = {{(XL-13){i.inst[31]}}, i.inst[31], i.inst[7], i.inst[30:25], i.inst[11:8], 1'b0};
  assign imm_u = {{(XL-32){i.inst[31]}}, i.inst[31:12], 12'b0};
  assign imm_j = {{(XL-21){i.inst[31]}}, i.inst[31], i.inst[19:12], i.inst[20], i.inst[30:21], 1'b0};

  always_comb begin
    case (i.inst[14:12])
      3'b010:  f3_alu = core_pkg::ALU_SLT;
      3'b100:  f3_alu = core_pkg::ALU_XOR;
      3'b110:  f3_alu = core_pkg::ALU_OR;
      3'b111:  f3_alu = core_pkg::ALU_AND;
      default: f3_alu = core_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    op_a    = rf.rdata1;
    op_b    = imm_i;
    alu_op  = core_pkg::ALU_ADD;
    writes  = 1'b0;
    mem_op  = core_pkg::MEM_NONE;
    next_pc = i.pc + XL'(4);
    case (opcode)
      core_pkg::OPC_OP_IMM: begin
        alu_op = f3_alu;
        writes = 1'b1;
      end
      core_pkg::OPC_OP: begin
        op_b   = rf.rdata2;
        alu_op = (i.inst[14:12] == 3'b000 && i.inst[30]) ? core_pkg::ALU_SUB : f3_alu;
        writes = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        op_b   = imm_u;
        alu_op = core_pkg::ALU_PASS_B;
        writes = 1'b1;
      end
      core_pkg::OPC_LOAD: begin
        writes = 1'b1;  // Address now, data from memory stage.
        mem_op = core_pkg::MEM_LOAD;
      end
      core_pkg::OPC_STORE: begin
        op_b   = imm_s;
        mem_op = core_pkg::MEM_STORE;
      end
      core_pkg::OPC_BRANCH: begin
        if (i.inst[14:12] == 3'b000 && rf.rdata1 == rf.rdata2) next_pc = i.pc + imm_b;
      end
      core_pkg::OPC_JAL: begin
        op_a    = i.pc;  // Link value is pc + 4.
        op_b    = XL'(4);
        writes  = 1'b1;
        next_pc = i.pc + imm_j;
      end
      default: ;  // Treated as NOP.
    endcase
  end

  always_comb begin
    case (alu_op)
      core_pkg::ALU_SUB: alu_res = op_a - op_b;
      core_pkg::ALU_AND: alu_res = op_a & op_b;
      core_pkg::ALU_OR:  alu_res = op_a | op_b;
      core_pkg::ALU_XOR: alu_res = op_a ^ op_b;
      core_pkg::ALU_SLT: alu_res = {{(XL-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_PASS_B: alu_res = op_b;
      default: alu_res = op_a + op_b;
    endcase
  end

  assign rd_wen = writes && (i.inst[11:7] != '0);
  assign i.ack  = 1'b1;
  assign hs     = i.req & i.ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o.req <= 1'b0;
    end else if (hs) begin
      o.req <= 1'b1;
    end else if (o.ack) begin
      o.req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hs) begin
      pc_q      <= i.pc;
      inst_q    <= i.inst;
      rd_q      <= rd_wen ? i.inst[11:7] : '0;
      rd_wen_q  <= rd_wen;
      wdata_q   <= alu_res;
      mem_op_q  <= mem_op;
      store_q   <= rf.rdata2;
      next_pc_q <= next_pc;
    end
  end

  assign o.pc         = o.req ? pc_q : '0;
  assign o.inst       = o.req ? inst_q : '0;
  assign o.rd         = o.req ? rd_q : '0;
  assign o.rd_wen     = o.req ? rd_wen_q : 1'b0;
  assign o.rd_wdata   = o.req ? wdata_q : '0;
  assign o.mem_op     = o.req ? mem_op_q : core_pkg::MEM_NONE;
  assign o.store_data = o.req ? store_q : '0;
  assign o.next_pc    = o.req ? next_pc_q : '0;

endmodule

// ==== core_fetch.sv ====
/* Fetch stage */
module core_fetch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_start,
  input  logic [core_pkg::XLEN-1:0]  i_pc,
  stage_if.src                       o
);

  logic [core_pkg::ILEN-1:0] imem [core_pkg::IMEM_DEPTH];
  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::ILEN-1:0] inst_q;

  initial $readmemh("program.hex", imem);

  always_ff @(posedge clk) begin
    if (rst) begin
      o.req <= 1'b0;
    end else if (i_start) begin
      o.req <= 1'b1;
    end else if (o.ack) begin
      o.req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      pc_q   <= i_pc;
      inst_q <= imem[i_pc[core_pkg::IMEM_AW+1:2]];  // Word index.
    end
  end

  assign o.pc   = o.req ? pc_q : '0;
  assign o.inst = o.req ? inst_q : '0;

  // Nothing decoded yet at this point.
  assign o.rd         = '0;
  assign o.rd_wen     = 1'b0;
  assign o.rd_wdata   = '0;
  assign o.mem_op     = core_pkg::MEM_NONE;
  assign o.store_data = '0;
  assign o.next_pc    = '0;

endmodule

// ==== core_if.sv ====
/* Stage and register file links */
interface stage_if;
  logic                          req;
  logic                          ack;
  logic [core_pkg::XLEN-1:0]     pc;
  logic [core_pkg::ILEN-1:0]     inst;
  logic [core_pkg::RIDX_W-1:0]   rd;
  logic                          rd_wen;
  logic [core_pkg::XLEN-1:0]     rd_wdata;  // Result, or address for memory ops.
  core_pkg::mem_op_e             mem_op;
  logic [core_pkg::XLEN-1:0]     store_data;
  logic [core_pkg::XLEN-1:0]     next_pc;

  modport src (
    output req, pc, inst, rd, rd_wen, rd_wdata, mem_op, store_data, next_pc,
    input  ack
  );

  modport dst (
    input  req, pc, inst, rd, rd_wen, rd_wdata, mem_op, store_data, next_pc,
    output ack
  );
endinterface

interface rf_if;
  logic [core_pkg::RIDX_W-1:0] rs1;
  logic [core_pkg::RIDX_W-1:0] rs2;
  logic [core_pkg::XLEN-1:0]   rdata1;
  logic [core_pkg::XLEN-1:0]   rdata2;

  modport user (output rs1, rs2, input rdata1, rdata2);
  modport regs (input rs1, rs2, output rdata1, rdata2);
endinterface

// ==== core_mem.sv ====
/* Memory stage */
module core_mem (
  input  logic  clk,
  input  logic  rst,
  stage_if.dst  i,
  stage_if.src  o
);

  logic [core_pkg::XLEN-1:0]    dmem [core_pkg::DMEM_DEPTH] = '{default: '0};
  logic [core_pkg::DMEM_AW-1:0] widx;
  logic                         hs;
  logic [core_pkg::XLEN-1:0]    pc_q;
  logic [core_pkg::ILEN-1:0]    inst_q;
  logic [core_pkg::RIDX_W-1:0]  rd_q;
  logic                         rd_wen_q;
  logic [core_pkg::XLEN-1:0]    wdata_q;
  core_pkg::mem_op_e            mem_op_q;
  logic [core_pkg::XLEN-1:0]    store_q;
  logic [core_pkg::XLEN-1:0]    next_pc_q;

  assign widx  = i.rd_wdata[core_pkg::DMEM_AW+2:3];  // Doubleword index.
  assign i.ack = 1'b1;
  assign hs    = i.req & i.ack;

  always_ff @(posedge clk) begin
    if (hs && i.mem_op == core_pkg::MEM_STORE) dmem[widx] <= i.store_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o.req <= 1'b0;
    end else if (hs) begin
      o.req <= 1'b1;
    end else if (o.ack) begin
      o.req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hs) begin
      pc_q      <= i.pc;
      inst_q    <= i.inst;
      rd_q      <= i.rd;
      rd_wen_q  <= i.rd_wen;
      wdata_q   <= (i.mem_op == core_pkg::MEM_LOAD) ? dmem[widx] : i.rd_wdata;
      mem_op_q  <= i.mem_op;
      store_q   <= i.store_data;
      next_pc_q <= i.next_pc;
    end
  end

  assign o.pc         = o.req ? pc_q : '0;
  assign o.inst       = o.req ? inst_q : '0;
  assign o.rd         = o.req ? rd_q : '0;
  assign o.rd_wen     = o.req ? rd_wen_q : 1'b0;
  assign o.rd_wdata   = o.req ? wdata_q : '0;
  assign o.mem_op     = o.req ? mem_op_q : core_pkg::MEM_NONE;
  assign o.store_data = o.req ? store_q : '0;
  assign o.next_pc    = o.req ? next_pc_q : '0;

endmodule

// ==== core_pkg.sv ====
/* Core definitions */
package core_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int RIDX_W     = 5;
  localparam int IMEM_DEPTH = 64;  // Instruction words.
  localparam int DMEM_DEPTH = 64;  // Doublewords.
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Major opcode field, inst[6:0].
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,  // Idle value on a link.
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT,
    ST_HALT
  } ctrl_state_e;

endpackage

// ==== core_regfile.sv ====
/* Register file */
module core_regfile (
  input  logic                         clk,
  input  logic                         rst,
  rf_if.regs                           rf,
  input  logic                         i_wen,
  input  logic [core_pkg::RIDX_W-1:0]  i_waddr,
  input  logic [core_pkg::XLEN-1:0]    i_wdata
);

  logic [core_pkg::XLEN-1:0] regs [2**core_pkg::RIDX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 2**core_pkg::RIDX_W; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;  // x0 stays zero.
    end
  end

  assign rf.rdata1 = regs[rf.rs1];
  assign rf.rdata2 = regs[rf.rs2];

endmodule

// ==== core_top.f ====
core_pkg.sv
core_if.sv
core_ctrl.sv
core_fetch.sv
core_exec.sv
core_mem.sv
core_wb_stage.sv
core_regfile.sv
core_top.sv
tb_core_top.sv

// ==== core_top.sv ====
/* Core top level */
module core_top (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         o_commit_valid,
  output logic [core_pkg::XLEN-1:0]    o_commit_pc,
  output logic [core_pkg::ILEN-1:0]    o_commit_inst,
  output logic [core_pkg::RIDX_W-1:0]  o_commit_rd,
  output logic [core_pkg::XLEN-1:0]    o_commit_wdata,
  output logic                         o_halt
);

  logic                         fetch_start;
  logic [core_pkg::XLEN-1:0]    fetch_pc;
  logic                         rf_wen;
  logic [core_pkg::RIDX_W-1:0]  rf_waddr;
  logic [core_pkg::XLEN-1:0]    rf_wdata;

  stage_if fch2ex ();
  stage_if ex2mem ();
  stage_if mem2wb ();
  stage_if wb2ctl ();
  rf_if    rf_bus ();

  core_ctrl ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .wb             (wb2ctl.dst),
    .o_fetch_start  (fetch_start),
    .o_fetch_pc     (fetch_pc),
    .o_rf_wen       (rf_wen),
    .o_rf_waddr     (rf_waddr),
    .o_rf_wdata     (rf_wdata),
    .o_commit_valid (o_commit_valid),
    .o_commit_pc    (o_commit_pc),
    .o_commit_inst  (o_commit_inst),
    .o_commit_rd    (o_commit_rd),
    .o_commit_wdata (o_commit_wdata),
    .o_halt         (o_halt)
  );

  core_fetch fetch_i (
    .clk     (clk),
    .rst     (rst),
    .i_start (fetch_start),
    .i_pc    (fetch_pc),
    .o       (fch2ex.src)
  );

  core_exec exec_i (.clk(clk), .rst(rst), .i(fch2ex.dst), .o(ex2mem.src), .rf(rf_bus.user));
  core_mem mem_i (.clk(clk), .rst(rst), .i(ex2mem.dst), .o(mem2wb.src));
  core_wb_stage wb_i (.clk(clk), .rst(rst), .i(mem2wb.dst), .o(wb2ctl.src));

  core_regfile regfile_i (
    .clk     (clk),
    .rst     (rst),
    .rf      (rf_bus.regs),
    .i_wen   (rf_wen),
    .i_waddr (rf_waddr),
    .i_wdata (rf_wdata)
  );

endmodule

// ==== core_wb_stage.sv ====
/* Writeback stage */
module core_wb_stage (
  input  logic  clk,
  input  logic  rst,
  stage_if.dst  i,
  stage_if.src  o
);

  logic                         hs;
  logic [core_pkg::XLEN-1:0]    pc_q;
  logic [core_pkg::ILEN-1:0]    inst_q;
  logic [core_pkg::RIDX_W-1:0]  rd_q;
  logic                         rd_wen_q;
  logic [core_pkg::XLEN-1:0]    wdata_q;
  logic [core_pkg::XLEN-1:0]    next_pc_q;

  assign i.ack = 1'b1;
  assign hs    = i.req & i.ack;

  // Result is held until control takes it.
  always_ff @(posedge clk) begin
    if (rst) begin
      o.req <= 1'b0;
    end else if (hs) begin
      o.req <= 1'b1;
    end else if (o.ack) begin
      o.req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hs) begin
      pc_q      <= i.pc;
      inst_q    <= i.inst;
      rd_q      <= i.rd;
      rd_wen_q  <= i.rd_wen;
      wdata_q   <= i.rd_wdata;
      next_pc_q <= i.next_pc;
    end
  end

  assign o.pc         = o.req ? pc_q : '0;
  assign o.inst       = o.req ? inst_q : '0;
  assign o.rd         = o.req ? rd_q : '0;
  assign o.rd_wen     = o.req ? rd_wen_q : 1'b0;
  assign o.rd_wdata   = o.req ? wdata_q : '0;
  assign o.next_pc    = o.req ? next_pc_q : '0;
  assign o.mem_op     = core_pkg::MEM_NONE;  // Memory access is done.
  assign o.store_data = '0;

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, from address 0 upward.
// Columns: instruction word, then the assembly it encodes.
00500093 // 0x00 addi x1, x0, 5
ffd00113 // 0x04 addi x2, x0, -3
002081b3 // 0x08 add  x3, x1, x2
40208233 // 0x0c sub  x4, x1, x2
0020f2b3 // 0x10 and  x5, x1, x2
0020e333 // 0x14 or   x6, x1, x2
0020c3b3 // 0x18 xor  x7, x1, x2
00112433 // 0x1c slt  x8, x2, x1
800004b7 // 0x20 lui  x9, 0x80000
00708013 // 0x24 addi x0, x1, 7
00903823 // 0x28 sd   x9, 16(x0)
01003503 // 0x2c ld   x10, 16(x0)
01803583 // 0x30 ld   x11, 24(x0)
00208463 // 0x34 beq  x1, x2, +8
00000463 // 0x38 beq  x0, x0, +8
00100613 // 0x3c addi x12, x0, 1
008006ef // 0x40 jal  x13, +8
00200613 // 0x44 addi x12, x0, 2
00000733 // 0x48 add  x14, x0, x0
00100073 // 0x4c ebreak

// ==== tb_core_top.sv ====
/* Core testbench */
module tb_core_top;

  localparam int          RESET_CYCLES     = 16;
  localparam int          EXPECTED_COMMITS = 18;  // Instructions on the program's path.
  localparam int          COMMIT_SPACING   = 5;
  localparam int          QUIET_CYCLES     = 20;
  localparam int          TIMEOUT_CYCLES   = RESET_CYCLES + COMMIT_SPACING * EXPECTED_COMMITS
                                             + QUIET_CYCLES + 40;
  localparam logic [31:0] EBREAK_WORD      = 32'h00100073;

  logic        clk;
  logic        rst;
  logic        o_commit_valid;
  logic [63:0] o_commit_pc;
  logic [31:0] o_commit_inst;
  logic [4:0]  o_commit_rd;
  logic [63:0] o_commit_wdata;
  logic        o_halt;

  logic [31:0] prog [64];
  logic [63:0] model_regs [32];
  logic [63:0] model_dmem [64];
  logic [63:0] model_pc;
  logic        model_halted;
  int          cycle_count;
  int          run_cycles;
  int          commit_count;
  int          last_commit_cycle;

  core_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .o_commit_valid (o_commit_valid),
    .o_commit_pc    (o_commit_pc),
    .o_commit_inst  (o_commit_inst),
    .o_commit_rd    (o_commit_rd),
    .o_commit_wdata (o_commit_wdata),
    .o_halt         (o_halt)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic mismatch(input string msg);
    abort_run($sformatf("Mismatch at time %0t: %s", $time, msg));
  endtask

  // Reference model of one instruction, straight from the RV64I rules.
  task automatic step_model(output logic [63:0] pc_o, output logic [31:0] inst_o,
                            output logic [4:0] rd_o, output logic [63:0] wdata_o);
    logic [31:0] inst;
    logic [63:0] rs1_val;
    logic [63:0] rs2_val;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] addr;
    logic [63:0] result;
    logic [63:0] next_pc;
    logic        writes;
    inst    = prog[model_pc[7:2]];
    rs1_val = model_regs[inst[19:15]];
    rs2_val = model_regs[inst[24:20]];
    imm_i   = {{52{inst[31]}}, inst[31:20]};
    imm_s   = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    result  = '0;
    writes  = 1'b0;
    next_pc = model_pc + 64'd4;
    case (inst[6:0])
      7'b0010011: begin
        if (inst[14:12] == 3'b000) begin
          result = rs1_val + imm_i;  // ADDI.
          writes = 1'b1;
        end
      end
      7'b0110011: begin
        writes = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: result = rs1_val + rs2_val;
          10'b0100000_000: result = rs1_val - rs2_val;
          10'b0000000_111: result = rs1_val & rs2_val;
          10'b0000000_110: result = rs1_val | rs2_val;
          10'b0000000_100: result = rs1_val ^ rs2_val;
          10'b0000000_010: result = {63'b0, $signed(rs1_val) < $signed(rs2_val)};
          default: writes = 1'b0;
        endcase
      end
      7'b0110111: begin
        result = {{32{inst[31]}}, inst[31:12], 12'b0};
        writes = 1'b1;
      end
      7'b0000011: begin
        addr   = rs1_val + imm_i;
        result = model_dmem[addr[8:3]];
        writes = 1'b1;
      end
      7'b0100011: begin
        addr                   = rs1_val + imm_s;
        model_dmem[addr[8:3]]  = rs2_val;
      end
      7'b1100011: begin
        if (inst[14:12] == 3'b000 && rs1_val == rs2_val) next_pc = model_pc + imm_b;
      end
      7'b1101111: begin
        result  = model_pc + 64'd4;
        writes  = 1'b1;
        next_pc = model_pc + imm_j;
      end
      7'b1110011: begin
        if (inst == EBREAK_WORD) model_halted = 1'b1;
      end
      default: ;
    endcase
    pc_o   = model_pc;
    inst_o = inst;
    if (writes && inst[11:7] != 5'd0) begin
      model_regs[inst[11:7]] = result;
      rd_o                   = inst[11:7];
      wdata_o                = result;
    end else begin
      rd_o    = 5'd0;  // No visible write.
      wdata_o = '0;
    end
    model_pc = next_pc;
  endtask

  task automatic check_commit();
    logic [63:0] exp_pc;
    logic [31:0] exp_inst;
    logic [4:0]  exp_rd;
    logic [63:0] exp_wdata;
    assert (!model_halted) else abort_run("Error: DUT committed an instruction after EBREAK");
    assert (run_cycles > 1) else abort_run("Error: DUT committed in the first cycle after reset");
    if (commit_count > 0) begin
      assert (cycle_count - last_commit_cycle == COMMIT_SPACING)
        else mismatch($sformatf("commits %0d cycles apart, expected %0d",
                                cycle_count - last_commit_cycle, COMMIT_SPACING));
    end
    last_commit_cycle = cycle_count;
    step_model(exp_pc, exp_inst, exp_rd, exp_wdata);
    assert (o_commit_pc == exp_pc)
      else mismatch($sformatf("commit pc %h, expected %h", o_commit_pc, exp_pc));
    assert (o_commit_inst == exp_inst)
      else mismatch($sformatf("pc %h inst %h, expected %h", exp_pc, o_commit_inst, exp_inst));
    assert (o_commit_rd == exp_rd)
      else mismatch($sformatf("pc %h rd %0d, expected %0d", exp_pc, o_commit_rd, exp_rd));
    assert (o_commit_wdata == exp_wdata)
      else mismatch($sformatf("pc %h wdata %h, expected %h", exp_pc, o_commit_wdata, exp_wdata));
    commit_count++;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Error: timeout, no halt after %0d cycles", cycle_count));
    end
  end

  // Outputs are registered, so they are sampled away from the rising edge.
  always @(negedge clk) begin
    if (rst) begin
      assert (o_commit_valid !== 1'b1) else abort_run("Error: commit during reset");
      assert (o_halt !== 1'b1) else abort_run("Error: halt during reset");
    end else begin
      run_cycles++;
      if (o_commit_valid === 1'b1) check_commit();
      assert (o_halt === model_halted)
        else mismatch($sformatf("o_halt %b, expected %b", o_halt, model_halted));
    end
  end

  initial begin
    for (int k = 0; k < 64; k++) begin
      prog[k]       = '0;
      model_dmem[k] = '0;
    end
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    $readmemh("program.hex", prog);
    model_pc          = '0;
    model_halted      = 1'b0;
    cycle_count       = 0;
    run_cycles        = 0;
    commit_count      = 0;
    last_commit_cycle = 0;
    clk               = 1'b0;
    rst               = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
    wait (model_halted);
    repeat (QUIET_CYCLES) @(posedge clk);  // Any late commit is caught by the monitor.
    assert (commit_count == EXPECTED_COMMITS) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      mismatch($sformatf("%0d commits, expected %0d", commit_count, EXPECTED_COMMITS));
    end
  end

endmodule
